// File: dv/timer_tb.sv
`timescale 1ns/100ps

module timer_tb;
  import timer_pkg::*;

  localparam int PERIOD_PWM = 20;
  localparam int PULSE_CYC  = 200;
  localparam int DIV_CYC    = 200;
  localparam int PWM_WIDTHS = 8;
  localparam int MIXED_CYC  = 400;
  // Reset, read-back, the three engine tests and mixed traffic
  localparam int TEST_CYC = 3 + 5 + 41 + (1 + PULSE_CYC) + (1 + DIV_CYC)
                          + (1 + PWM_WIDTHS * (1 + 3 * PERIOD_PWM)) + (1 + MIXED_CYC) + 1;
  localparam int MAX_CYC  = TEST_CYC + 100;

  logic              clk;
  logic              rst;
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [CNT_W-1:0]  wr_data;
  logic [ADDR_W-1:0] rd_addr;
  logic [CNT_W-1:0]  rd_data;
  logic              tick;
  logic              square;
  logic              pwm;

  int seed;
  int errors;
  int tests;
  int err_mark;
  int cycles = 0;

  // Model state
  int   m_limit;
  int   m_divisor;
  int   m_width;
  int   m_ctrl;
  logic m_rs_pulse;
  logic m_rs_div;
  logic m_rs_pwm;
  int   m_cnt_pulse;
  int   m_cnt_div;
  int   m_cnt_pwm;
  logic m_tick;
  logic m_square;
  logic m_pwm;

  timer_top #(
    .PWM_PERIOD (PERIOD_PWM)
  ) dut_i (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .tick    (tick),
    .square  (square),
    .pwm     (pwm)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Cycle model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic model_reset();
    m_limit     = 9;
    m_divisor   = 2;
    m_width     = 0;
    m_ctrl      = 0;
    m_rs_pulse  = 1'b0;
    m_rs_div    = 1'b0;
    m_rs_pwm    = 1'b0;
    m_cnt_pulse = 0;
    m_cnt_div   = 0;
    m_cnt_pwm   = 0;
    m_tick      = 1'b0;
    m_square    = 1'b0;
    m_pwm       = 1'b0;
  endtask

  task automatic model_step();
    logic wl;
    logic wd;
    logic ww;
    logic wc;
    int   flip;
    // Engines see the configuration from before this edge
    if (!m_ctrl[0] || m_rs_pulse) m_cnt_pulse = 0;
    else if (m_cnt_pulse >= m_limit) m_cnt_pulse = 0;
    else m_cnt_pulse = m_cnt_pulse + 1;
    m_tick = m_ctrl[0] && (m_cnt_pulse == m_limit);
    if (!m_ctrl[1] || m_rs_div) m_cnt_div = 0;
    else if (m_divisor < 2) m_cnt_div = m_cnt_div;
    else if (m_cnt_div >= m_divisor - 1) m_cnt_div = 0;
    else m_cnt_div = m_cnt_div + 1;
    m_square = m_ctrl[1] && (m_divisor >= 2) && (m_cnt_div >= m_divisor / 2);
    if (!m_ctrl[2] || m_rs_pwm) m_cnt_pwm = 0;
    else if (m_cnt_pwm == PERIOD_PWM - 1) m_cnt_pwm = 0;
    else m_cnt_pwm = m_cnt_pwm + 1;
    m_pwm = m_ctrl[2] && (m_cnt_pwm < m_width);
    // Register writes and the restarts they cause
    wl = wr_en && (wr_addr == ADDR_LIMIT);
    wd = wr_en && (wr_addr == ADDR_DIVISOR);
    ww = wr_en && (wr_addr == ADDR_WIDTH);
    wc = wr_en && (wr_addr == ADDR_CTRL);
    flip = wc ? ((int'(wr_data) & 7) ^ m_ctrl) : 0;
    m_rs_pulse = wl || flip[0];
    m_rs_div   = wd || flip[1];
    m_rs_pwm   = ww || flip[2];
    if (wl) m_limit = int'(wr_data);
    if (wd) m_divisor = int'(wr_data);
    if (ww) m_width = int'(wr_data);
    if (wc) m_ctrl = int'(wr_data) & 7;
  endtask

  function automatic int reg_value(input logic [ADDR_W-1:0] a);
    case (a)
      ADDR_LIMIT:   return m_limit;
      ADDR_DIVISOR: return m_divisor;
      ADDR_WIDTH:   return m_width;
      default:      return m_ctrl;
    endcase
  endfunction

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYC) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYC);
      $display("Simulation finished: FAIL");
      $finish;
    end else if (rst) begin
      model_reset();
    end else begin
      model_step();
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
      errors = errors + 1;
    end
  endtask

  function automatic int pick(input int n);
    return {$random(seed)} % n;
  endfunction

  // Check outputs from the last edge, then drive the next inputs
  task automatic run_cycle(input logic we, input logic [ADDR_W-1:0] wa,
                           input logic [CNT_W-1:0] wd);
    @(negedge clk);
    check_val("tick", 32'(m_tick), 32'(tick));
    check_val("square", 32'(m_square), 32'(square));
    check_val("pwm", 32'(m_pwm), 32'(pwm));
    check_val("rd_data", reg_value(rd_addr), 32'(rd_data));
    wr_en   = we;
    wr_addr = wa;
    wr_data = wd;
    rd_addr = wa;
  endtask

  task automatic idle_cycle();
    run_cycle(1'b0, rd_addr, '0);
  endtask

  task automatic rand_write();
    int a;
    int d;
    a = pick(4);
    case (a)
      0:       d = pick(16);
      1:       d = pick(13);
      2:       d = pick(23);
      default: d = pick(8);
    endcase
    run_cycle(1'b1, ADDR_W'(a), CNT_W'(d));
  endtask

  task automatic end_test(input string name);
    tests = tests + 1;
    $display("Test %0d %s finished with %0d errors", tests, name, errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    int w;
    seed     = 17560;
    errors   = 0;
    tests    = 0;
    err_mark = 0;
    rst      = 1'b1;
    wr_en    = 1'b0;
    wr_addr  = '0;
    wr_data  = '0;
    rd_addr  = '0;

    repeat (3) run_cycle(1'b0, ADDR_LIMIT, '0);
    rst = 1'b0;
    for (int a = 0; a < 4; a++) run_cycle(1'b0, ADDR_W'(a), '0);
    idle_cycle();
    end_test("reset_state");

    for (int i = 0; i < 40; i++) run_cycle(1'b1, ADDR_W'(pick(4)), CNT_W'(pick(256)));
    idle_cycle();
    end_test("register_readback");

    run_cycle(1'b1, ADDR_CTRL, 8'd1);
    for (int i = 0; i < PULSE_CYC; i++) begin
      if (i == 0) run_cycle(1'b1, ADDR_LIMIT, 8'd0);
      else if (i % 25 == 0) run_cycle(1'b1, ADDR_LIMIT, CNT_W'(pick(16)));
      else idle_cycle();
    end
    end_test("pulse_counter");

    run_cycle(1'b1, ADDR_CTRL, 8'd2);
    for (int i = 0; i < DIV_CYC; i++) begin
      if (i == 0) run_cycle(1'b1, ADDR_DIVISOR, 8'd0);
      else if (i == 25) run_cycle(1'b1, ADDR_DIVISOR, 8'd1);
      else if (i % 25 == 0) run_cycle(1'b1, ADDR_DIVISOR, CNT_W'(pick(13)));
      else idle_cycle();
    end
    end_test("square_divider");

    run_cycle(1'b1, ADDR_CTRL, 8'd4);
    for (int k = 0; k < PWM_WIDTHS; k++) begin
      w = (k == 0) ? 0 : (k == 1) ? 20 : (k == 2) ? 22 : pick(23);
      run_cycle(1'b1, ADDR_WIDTH, CNT_W'(w));
      repeat (3 * PERIOD_PWM) idle_cycle();
    end
    end_test("pwm_gen");

    run_cycle(1'b1, ADDR_CTRL, 8'd7);
    for (int i = 0; i < MIXED_CYC; i++) begin
      if (pick(8) == 0) rand_write();
      else idle_cycle();
    end
    idle_cycle();
    end_test("mixed_traffic");

    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the timer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f vlog.f --top-module timer_tb -o timer_sim

sim_out=$(./obj_dir/timer_sim) || true
echo "$sim_out"

# Pass only when the testbench printed its pass line
echo "$sim_out" | grep -q "Simulation finished: PASS"

// File: src/pulse_counter.sv
`timescale 1ns/100ps

module pulse_counter (
  input  logic            clk,
  input  logic            rst,
  input  timer_pkg::cfg_t cfg,
  output logic            tick
);
  import timer_pkg::*;

  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cnt_next;

  // Count 0 .. limit then wrap
  always_comb begin
    if (!cfg.en_pulse || cfg.restart_pulse) begin
      cnt_next = '0;
    end else if (cnt >= cfg.limit) begin
      cnt_next = '0;
    end else begin
      cnt_next = cnt + 1'b1;
    end
  end

  // Tick tracks the count loaded at the same edge
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else begin
      cnt  <= cnt_next;
      tick <= cfg.en_pulse && (cnt_next == cfg.limit);
    end
  end

  // Disabled with no restart pending
  a_tick_needs_en: assert property (
    @(posedge clk) disable iff (rst) (!cfg.en_pulse && !cfg.restart_pulse) |-> !tick
  ) else $error("tick while pulse counter disabled");

endmodule

// File: src/pwm_gen.sv
`timescale 1ns/100ps

module pwm_gen #(
  parameter int PWM_PERIOD = 255
) (
  input  logic            clk,
  input  logic            rst,
  input  timer_pkg::cfg_t cfg,
  output logic            pwm
);
  import timer_pkg::*;

  localparam logic [CNT_W-1:0] LAST = CNT_W'(PWM_PERIOD - 1);

  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cnt_next;

  // Free-running period counter
  always_comb begin
    if (!cfg.en_pwm || cfg.restart_pwm) begin
      cnt_next = '0;
    end else if (cnt == LAST) begin
      cnt_next = '0;
    end else begin
      cnt_next = cnt + 1'b1;
    end
  end

  // width 0 stays low, width >= period stays high
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
      pwm <= 1'b0;
    end else begin
      cnt <= cnt_next;
      pwm <= cfg.en_pwm && (cnt_next < cfg.width);
    end
  end

  a_cnt_below_period: assert property (
    @(posedge clk) disable iff (rst) int'(cnt) < PWM_PERIOD
  ) else $error("pwm count reached period");

endmodule

// File: src/square_divider.sv
`timescale 1ns/100ps

module square_divider (
  input  logic            clk,
  input  logic            rst,
  input  timer_pkg::cfg_t cfg,
  output logic            square
);
  import timer_pkg::*;

  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cnt_next;
  logic [CNT_W-1:0] half;
  logic             div_ok;

  assign half   = cfg.divisor >> 1;
  assign div_ok = cfg.divisor >= 8'd2;

  always_comb begin
    if (!cfg.en_div || cfg.restart_div) begin
      cnt_next = '0;
    end else if (!div_ok) begin
      // Divisor 0 or 1 freezes the count
      cnt_next = cnt;
    end else if (cnt >= cfg.divisor - 1'b1) begin
      cnt_next = '0;
    end else begin
      cnt_next = cnt + 1'b1;
    end
  end

  // Upper half of the period is high
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt    <= '0;
      square <= 1'b0;
    end else begin
      cnt    <= cnt_next;
      square <= cfg.en_div && div_ok && (cnt_next >= half);
    end
  end

  a_cnt_in_range: assert property (
    @(posedge clk) disable iff (rst)
      (div_ok && !cfg.restart_div) |-> (cnt < cfg.divisor)
  ) else $error("divider count out of range");

endmodule

// File: src/timer_pkg.sv
package timer_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int CNT_W  = 8;
  localparam int ADDR_W = 2;

  // Register map
  localparam logic [ADDR_W-1:0] ADDR_LIMIT   = 2'd0;
  localparam logic [ADDR_W-1:0] ADDR_DIVISOR = 2'd1;
  localparam logic [ADDR_W-1:0] ADDR_WIDTH   = 2'd2;
  localparam logic [ADDR_W-1:0] ADDR_CTRL    = 2'd3;

  // CTRL bit positions, remaining bits read as zero
  localparam int CTRL_W        = 3;
  localparam int CTRL_EN_PULSE = 0;
  localparam int CTRL_EN_DIV   = 1;
  localparam int CTRL_EN_PWM   = 2;

  // Values after reset
  localparam logic [CNT_W-1:0] RST_LIMIT   = 8'd9;
  localparam logic [CNT_W-1:0] RST_DIVISOR = 8'd2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Configuration from the register block to the engines
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [CNT_W-1:0] limit;
    logic [CNT_W-1:0] divisor;
    logic [CNT_W-1:0] width;
    logic             en_pulse;
    logic             en_div;
    logic             en_pwm;
    // One-cycle strobes
    logic             restart_pulse;
    logic             restart_div;
    logic             restart_pwm;
  } cfg_t;

endpackage

// File: src/timer_regs.sv
`timescale 1ns/100ps

module timer_regs (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         wr_en,
  input  logic [timer_pkg::ADDR_W-1:0] wr_addr,
  input  logic [timer_pkg::CNT_W-1:0]  wr_data,
  input  logic [timer_pkg::ADDR_W-1:0] rd_addr,
  output logic [timer_pkg::CNT_W-1:0]  rd_data,
  output timer_pkg::cfg_t              cfg
);
  import timer_pkg::*;

  logic [CNT_W-1:0]  limit_q;
  logic [CNT_W-1:0]  divisor_q;
  logic [CNT_W-1:0]  width_q;
  logic [CTRL_W-1:0] ctrl_q;
  logic              wr_ctrl;
  logic [CTRL_W-1:0] en_flip;
  logic              restart_pulse_q;
  logic              restart_div_q;
  logic              restart_pwm_q;

  // Enable bits that a CTRL write is about to change
  assign wr_ctrl = wr_en && (wr_addr == ADDR_CTRL);
  assign en_flip = wr_ctrl ? (wr_data[CTRL_W-1:0] ^ ctrl_q) : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      limit_q         <= RST_LIMIT;
      divisor_q       <= RST_DIVISOR;
      width_q         <= '0;
      ctrl_q          <= '0;
      restart_pulse_q <= 1'b0;
      restart_div_q   <= 1'b0;
      restart_pwm_q   <= 1'b0;
    end else begin
      if (wr_en && (wr_addr == ADDR_LIMIT)) limit_q <= wr_data;
      if (wr_en && (wr_addr == ADDR_DIVISOR)) divisor_q <= wr_data;
      if (wr_en && (wr_addr == ADDR_WIDTH)) width_q <= wr_data;
      if (wr_ctrl) ctrl_q <= wr_data[CTRL_W-1:0];
      restart_pulse_q <= (wr_en && (wr_addr == ADDR_LIMIT)) || en_flip[CTRL_EN_PULSE];
      restart_div_q   <= (wr_en && (wr_addr == ADDR_DIVISOR)) || en_flip[CTRL_EN_DIV];
      restart_pwm_q   <= (wr_en && (wr_addr == ADDR_WIDTH)) || en_flip[CTRL_EN_PWM];
    end
  end

  always_comb begin
    cfg.limit         = limit_q;
    cfg.divisor       = divisor_q;
    cfg.width         = width_q;
    cfg.en_pulse      = ctrl_q[CTRL_EN_PULSE];
    cfg.en_div        = ctrl_q[CTRL_EN_DIV];
    cfg.en_pwm        = ctrl_q[CTRL_EN_PWM];
    cfg.restart_pulse = restart_pulse_q;
    cfg.restart_div   = restart_div_q;
    cfg.restart_pwm   = restart_pwm_q;
  end

  // Read-back
  always_comb begin
    case (rd_addr)
      ADDR_LIMIT:   rd_data = limit_q;
      ADDR_DIVISOR: rd_data = divisor_q;
      ADDR_WIDTH:   rd_data = width_q;
      default:      rd_data = {{(CNT_W-CTRL_W){1'b0}}, ctrl_q};
    endcase
  end

  // Strobes stay quiet once reset has been seen
  a_no_restart_in_rst: assert property (
    @(posedge clk) rst |=> !(cfg.restart_pulse || cfg.restart_div || cfg.restart_pwm)
  ) else $error("restart strobe raised during reset");

endmodule

// File: src/timer_top.sv
`timescale 1ns/100ps

module timer_top #(
  parameter int PWM_PERIOD = 255
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         wr_en,
  input  logic [timer_pkg::ADDR_W-1:0] wr_addr,
  input  logic [timer_pkg::CNT_W-1:0]  wr_data,
  input  logic [timer_pkg::ADDR_W-1:0] rd_addr,
  output logic [timer_pkg::CNT_W-1:0]  rd_data,
  output logic                         tick,
  output logic                         square,
  output logic                         pwm
);
  import timer_pkg::*;

  cfg_t cfg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register block
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  timer_regs regs_i (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .cfg     (cfg)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Engines
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  pulse_counter pulse_i (
    .clk  (clk),
    .rst  (rst),
    .cfg  (cfg),
    .tick (tick)
  );

  square_divider div_i (
    .clk    (clk),
    .rst    (rst),
    .cfg    (cfg),
    .square (square)
  );

  pwm_gen #(
    .PWM_PERIOD (PWM_PERIOD)
  ) pwm_i (
    .clk (clk),
    .rst (rst),
    .cfg (cfg),
    .pwm (pwm)
  );

endmodule

// File: vlog.f
src/timer_pkg.sv
src/timer_regs.sv
src/pulse_counter.sv
src/square_divider.sv
src/pwm_gen.sv
src/timer_top.sv
dv/timer_tb.sv
